// File: verilog/fpu_config.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// build-time constants for the fpu coprocessor
// pipeline latency, bus address width, register map
// include wherever these macros are needed
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef FPU_CONFIG_SVH
`define FPU_CONFIG_SVH

// clock edges from pipe inputs to a valid result
`define FPU_LATENCY 3

// wishbone byte address width, 8 words
`define FPU_AW 5

// register word indices, byte offset = index * 4
`define FPU_REG_OPA    3'd0
`define FPU_REG_OPB    3'd1
`define FPU_REG_CTRL   3'd2
`define FPU_REG_STATUS 3'd3
`define FPU_REG_RESULT 3'd4

`endif

// File: verilog/fpu_float_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single precision float types and codes
// shared by the pipeline and the register block
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package fpu_float_pkg;

   // one float word, raw or split into ieee fields
   typedef union packed {
      logic [31:0] bits;        // whole word moves
      struct packed {
         logic        sign;
         logic [7:0]  exp;      // biased exponent
         logic [22:0] frac;     // hidden one not stored
      } f;
   } float_t;

   // ctrl[1:0], code 3 reserved, runs as add
   typedef enum logic [1:0] {OP_ADD = 2'd0, OP_SUB = 2'd1, OP_MUL = 2'd2} fpu_op_e;

   // ctrl[4:2], unlisted codes round to nearest even
   typedef enum logic [2:0] {RM_RNE = 3'd0, RM_RTZ = 3'd1} fpu_rm_e;

   // exception flag positions, risc-v fflags order
   localparam int FLAG_NV = 4;
   localparam int FLAG_DZ = 3;     // never raised
   localparam int FLAG_OF = 2;
   localparam int FLAG_UF = 1;
   localparam int FLAG_NX = 0;

   localparam logic [31:0] QNAN     = 32'h7FC0_0000;   // canonical nan
   localparam int          EXP_BIAS = 127;

endpackage

// File: verilog/fpu_bus_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register map types for the wishbone front end
// status word bit layout lives here too
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package fpu_bus_pkg;

   // word index, byte address bits [4:2]
   typedef logic [2:0] reg_idx_t;

   // status word
   localparam int ST_BUSY  = 0;    // op in flight
   localparam int ST_DONE  = 1;    // result register valid
   localparam int ST_FLAGS = 8;    // flags in [12:8]

endpackage

// File: verilog/fpu_pipe.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// three stage single precision add/sub/mul pipeline
// free running, no valid bit, result FPU_LATENCY edges after inputs
// subnormals in and out flush to zero
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "fpu_config.svh"

module fpu_pipe (
   input  logic                   clk,
   input  logic                   nrst,
   input  fpu_float_pkg::float_t  opa,
   input  fpu_float_pkg::float_t  opb,
   input  fpu_float_pkg::fpu_op_e op,
   input  fpu_float_pkg::fpu_rm_e frm,
   output fpu_float_pkg::float_t  result,
   output logic [4:0]             flags
);
   import fpu_float_pkg::*;

   // stage 1 decode and align
   logic        is_mul;
   logic        sb_eff;        // b sign after sub inversion
   logic        s_mul;
   logic        a_zero;
   logic        b_zero;
   logic        a_inf;
   logic        b_inf;
   logic        a_nan;
   logic        b_nan;
   logic [23:0] ma;
   logic [23:0] mb;
   logic        swap;          // b larger in magnitude
   logic [7:0]  e_big;
   logic [7:0]  e_sml;
   logic [7:0]  ediff;
   logic [23:0] m_big;
   logic [23:0] m_sml;
   logic [4:0]  sh;
   logic [49:0] sh_ext;
   logic        spec;
   logic [31:0] spec_word;
   logic        nv;

   always_comb begin
      is_mul = (op == OP_MUL);
      sb_eff = opb.f.sign ^ (op == OP_SUB);
      s_mul  = opa.f.sign ^ opb.f.sign;
      a_zero = (opa.f.exp == 8'h00);             // zero or subnormal
      b_zero = (opb.f.exp == 8'h00);
      a_inf  = (opa.f.exp == 8'hFF) && (opa.f.frac == 23'd0);
      b_inf  = (opb.f.exp == 8'hFF) && (opb.f.frac == 23'd0);
      a_nan  = (opa.f.exp == 8'hFF) && (opa.f.frac != 23'd0);
      b_nan  = (opb.f.exp == 8'hFF) && (opb.f.frac != 23'd0);
      ma     = a_zero ? 24'd0 : {1'b1, opa.f.frac};
      mb     = b_zero ? 24'd0 : {1'b1, opb.f.frac};

      // order by magnitude, raw compare of exp:frac
      swap   = (opb.bits[30:0] > opa.bits[30:0]);
      e_big  = swap ? opb.f.exp : opa.f.exp;
      e_sml  = swap ? opa.f.exp : opb.f.exp;
      m_big  = swap ? mb : ma;
      m_sml  = swap ? ma : mb;
      ediff  = e_big - e_sml;
      sh     = (ediff > 8'd26) ? 5'd26 : ediff[4:0];   // past 26 all goes to sticky
      sh_ext = {m_sml, 26'd0} >> sh;

      // special cases bypass the arithmetic
      spec      = 1'b0;
      spec_word = QNAN;
      nv        = 1'b0;
      if (a_nan || b_nan) begin
         spec = 1'b1;
      end else if (is_mul) begin
         if ((a_inf && b_zero) || (a_zero && b_inf)) begin
            spec = 1'b1;                          // 0 x inf
            nv   = 1'b1;
         end else if (a_inf || b_inf) begin
            spec      = 1'b1;
            spec_word = {s_mul, 8'hFF, 23'd0};
         end else if (a_zero || b_zero) begin
            spec      = 1'b1;
            spec_word = {s_mul, 31'd0};
         end
      end else begin
         if (a_inf && b_inf && (opa.f.sign != sb_eff)) begin
            spec = 1'b1;                          // inf - inf
            nv   = 1'b1;
         end else if (a_inf) begin
            spec      = 1'b1;
            spec_word = {opa.f.sign, 8'hFF, 23'd0};
         end else if (b_inf) begin
            spec      = 1'b1;
            spec_word = {sb_eff, 8'hFF, 23'd0};
         end else if (a_zero && b_zero) begin
            spec      = 1'b1;                     // -0 only when both negative
            spec_word = {opa.f.sign & sb_eff, 31'd0};
         end
      end
   end

   logic        s1_mul;
   fpu_rm_e     s1_frm;
   logic        s1_spec;
   logic        s1_nv;
   logic [31:0] s1_spec_word;
   logic        s1_sign;
   logic        s1_sub;        // effective subtraction
   logic [26:0] s1_big;        // mantissa, guard, round, sticky
   logic [26:0] s1_sml;
   logic [7:0]  s1_ea;         // larger exponent for add
   logic [7:0]  s1_eb;
   logic [47:0] s1_prod;

   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         s1_mul  <= 1'b0;
         s1_frm  <= RM_RNE;
         s1_spec <= 1'b0;
         s1_nv   <= 1'b0;
      end else begin
         s1_mul  <= is_mul;
         s1_frm  <= frm;
         s1_spec <= spec;
         s1_nv   <= nv;
      end
   end

   always_ff @(posedge clk) begin
      s1_spec_word <= spec_word;
      s1_sign      <= is_mul ? s_mul : (swap ? sb_eff : opa.f.sign);
      s1_sub       <= opa.f.sign ^ sb_eff;
      s1_big       <= {m_big, 3'd0};
      s1_sml       <= {sh_ext[49:24], |sh_ext[23:0]};
      s1_ea        <= is_mul ? opa.f.exp : e_big;
      s1_eb        <= opb.f.exp;
      s1_prod      <= ma * mb;
   end

   // stage 2, sum or product into one 28 bit format, int bits [27:26]
   logic [27:0] add_sum;
   logic [27:0] mul_m;
   logic [9:0]  mul_exp;

   always_comb begin
      if (s1_sub) begin
         add_sum = {1'b0, s1_big} - {1'b0, s1_sml};
      end else begin
         add_sum = {1'b0, s1_big} + {1'b0, s1_sml};
      end
      mul_m   = {s1_prod[47:21], |s1_prod[20:0]};
      mul_exp = {2'b00, s1_ea} + {2'b00, s1_eb} - 10'(EXP_BIAS);
   end

   fpu_rm_e            s2_frm;
   logic               s2_spec;
   logic               s2_nv;
   logic [31:0]        s2_spec_word;
   logic [27:0]        s2_m;
   logic signed [9:0]  s2_exp;
   logic               s2_sign;

   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         s2_frm  <= RM_RNE;
         s2_spec <= 1'b0;
         s2_nv   <= 1'b0;
      end else begin
         s2_frm  <= s1_frm;
         s2_spec <= s1_spec;
         s2_nv   <= s1_nv;
      end
   end

   always_ff @(posedge clk) begin
      s2_spec_word <= s1_spec_word;
      s2_m         <= s1_mul ? mul_m : add_sum;
      s2_exp       <= s1_mul ? mul_exp : {2'b00, s1_ea};
      s2_sign      <= s1_sign;
   end

   // stage 3, normalize and round
   function automatic logic [4:0] lzc27(input logic [26:0] v);
      logic [4:0] cnt;
      cnt = 5'd27;
      for (int i = 0; i < 27; i++) begin
         if (v[i]) cnt = 5'(26 - i);       // highest set bit wins
      end
      return cnt;
   endfunction

   logic [4:0]        lz;
   logic [26:0]       n;             // leading one at bit 26
   logic signed [9:0] en;
   logic signed [9:0] er;
   logic              g;
   logic              rs;
   logic              inc;
   logic [24:0]       mant;
   logic [31:0]       word;
   logic [4:0]        fl;

   always_comb begin
      lz = lzc27(s2_m[26:0]);
      if (s2_m[27]) begin
         n  = {s2_m[27:2], s2_m[1] | s2_m[0]};   // carry out, shift right
         en = s2_exp + 10'sd1;
      end else begin
         n  = s2_m[26:0] << lz;                   // cancellation
         en = s2_exp - 10'(lz);
      end
      g    = n[2];
      rs   = n[1] | n[0];
      inc  = (s2_frm != RM_RTZ) && g && (rs || n[3]);   // ties to even
      mant = {1'b0, n[26:3]} + 25'(inc);
      er   = en + 10'(mant[24]);

      word = 32'd0;
      fl   = 5'd0;
      fl[FLAG_DZ] = 1'b0;
      if (s2_spec) begin
         word        = s2_spec_word;
         fl[FLAG_NV] = s2_nv;
      end else if (s2_m == 28'd0) begin
         word = 32'd0;                            // exact cancellation, +0
      end else if (en <= 10'sd0) begin
         word        = {s2_sign, 31'd0};          // flush to zero
         fl[FLAG_UF] = 1'b1;
         fl[FLAG_NX] = 1'b1;
      end else if (er >= 10'sd255) begin
         if (s2_frm == RM_RTZ) begin
            word = {s2_sign, 8'hFE, 23'h7F_FFFF}; // largest finite
         end else begin
            word = {s2_sign, 8'hFF, 23'd0};
         end
         fl[FLAG_OF] = 1'b1;
         fl[FLAG_NX] = 1'b1;
      end else begin
         word        = {s2_sign, er[7:0], mant[24] ? mant[23:1] : mant[22:0]};
         fl[FLAG_NX] = g | rs;
      end
   end

   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         result <= '0;
         flags  <= 5'd0;
      end else begin
         result.bits <= word;
         flags       <= fl;
      end
   end

endmodule

// File: verilog/fpu_seq_fsm.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sequencer for one fpu operation at a time
// issue on request, wait for the timer, then capture
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module fpu_seq_fsm (
   input  logic clk,
   input  logic nrst,
   input  logic issue_req,   // ctrl write accepted
   input  logic expired,     // pipe output valid this cycle
   output logic load,        // start latency timer
   output logic capture,     // latch result and flags
   output logic busy,
   output logic done
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_WAIT,                // op in the pipeline
      S_COMPLETE             // result held in the bus regs
   } state_t;

   state_t state;
   logic   issue;

   // a request in S_WAIT is dropped
   assign issue = issue_req && (state != S_WAIT);
   assign load  = issue;

   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         state   <= S_IDLE;
         capture <= 1'b0;
      end else begin
         capture <= expired && (state == S_WAIT);  // one cycle after expiry
         case (state)
            S_IDLE, S_COMPLETE: begin
               if (issue) state <= S_WAIT;
            end
            S_WAIT: begin
               if (expired) state <= S_COMPLETE;
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   // busy falls and done rises together with capture
   assign busy = (state == S_WAIT);
   assign done = (state == S_COMPLETE);

endmodule

// File: verilog/fpu_latency_timer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one-shot down counter for the pipeline latency
// expired pulses FPU_LATENCY cycles after load
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "fpu_config.svh"

module fpu_latency_timer (
   input  logic clk,
   input  logic nrst,
   input  logic load,
   output logic expired
);

   localparam int CW = $clog2(`FPU_LATENCY + 1);

   logic [CW-1:0] cnt;
   logic          running;

   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         cnt     <= '0;
         running <= 1'b0;
      end else if (load) begin
         cnt     <= CW'(`FPU_LATENCY - 1);   // load cycle counts as one
         running <= 1'b1;
      end else if (running) begin
         if (cnt == '0) running <= 1'b0;  // idle until next load
         else cnt <= cnt - 1'b1;
      end
   end

   assign expired = running && (cnt == '0);

endmodule

// File: verilog/fpu_wb_regs.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// wishbone classic slave register block for the fpu
// opa, opb, ctrl writable, status and result read only
// every access acked one cycle after the request
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "fpu_config.svh"

module fpu_wb_regs (
   input  logic                   clk,
   input  logic                   nrst,
   input  logic                   cyc,
   input  logic                   stb,
   input  logic                   we,
   input  logic [`FPU_AW-1:0]     adr,
   input  logic [31:0]            dat_w,
   input  logic [3:0]             sel,
   output logic [31:0]            dat_r,
   output logic                   ack,
   output fpu_float_pkg::float_t  opa,
   output fpu_float_pkg::float_t  opb,
   output fpu_float_pkg::fpu_op_e op,
   output fpu_float_pkg::fpu_rm_e frm,
   output logic                   issue_req,
   input  logic                   capture,
   input  logic                   busy,
   input  logic                   done,
   input  fpu_float_pkg::float_t  result,
   input  logic [4:0]             flags
);
   import fpu_float_pkg::*;
   import fpu_bus_pkg::*;

   logic        req;       // new request, ack not yet given
   logic        wr_ok;
   logic        rd_ok;
   reg_idx_t    idx;
   float_t      res_q;
   logic [4:0]  flags_q;
   logic [31:0] status;
   logic [31:0] rd_mux;

   assign req   = cyc && stb && !ack;
   assign idx   = reg_idx_t'(adr[`FPU_AW-1:2]);   // byte to word
   assign wr_ok = req && we && (&sel);            // full words only
   assign rd_ok = req && !we;

   always_comb begin
      status           = 32'd0;
      status[ST_BUSY]  = busy;
      status[ST_DONE]  = done;
      status[ST_FLAGS +: 5] = flags_q;
   end

   always_comb begin
      case (idx)
         `FPU_REG_OPA:    rd_mux = opa.bits;
         `FPU_REG_OPB:    rd_mux = opb.bits;
         `FPU_REG_CTRL:   rd_mux = {27'd0, frm, op};
         `FPU_REG_STATUS: rd_mux = status;
         `FPU_REG_RESULT: rd_mux = res_q.bits;
         default:         rd_mux = 32'd0;          // unmapped
      endcase
   end

   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         ack       <= 1'b0;
         dat_r     <= 32'd0;
         opa       <= '0;
         opb       <= '0;
         op        <= OP_ADD;
         frm       <= RM_RNE;
         issue_req <= 1'b0;
         res_q     <= '0;
         flags_q   <= 5'd0;
      end else begin
         ack       <= req;          // low again the cycle after
         issue_req <= 1'b0;
         if (rd_ok) dat_r <= rd_mux;
         if (wr_ok) begin
            case (idx)
               `FPU_REG_OPA: opa.bits <= dat_w;
               `FPU_REG_OPB: opb.bits <= dat_w;
               `FPU_REG_CTRL: begin
                  if (!busy) begin              // op in flight keeps its ctrl
                     op        <= fpu_op_e'(dat_w[1:0]);
                     frm       <= fpu_rm_e'(dat_w[4:2]);
                     issue_req <= 1'b1;
                  end
               end
               default: ;                       // read only or unmapped
            endcase
         end
         if (capture) begin
            res_q   <= result;
            flags_q <= flags;
         end
      end
   end

endmodule

// File: verilog/fpu_wb_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fpu coprocessor top, wishbone classic slave
// regs, sequencer, latency timer and pipeline
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "fpu_config.svh"

module fpu_wb_top (
   input  logic               clk,
   input  logic               nrst,
   input  logic               cyc,
   input  logic               stb,
   input  logic               we,
   input  logic [`FPU_AW-1:0] adr,
   input  logic [31:0]        dat_w,
   input  logic [3:0]         sel,
   output logic [31:0]        dat_r,
   output logic               ack
);
   import fpu_float_pkg::*;

   float_t     opa_w;        // straight from the operand regs
   float_t     opb_w;
   fpu_op_e    op_w;
   fpu_rm_e    frm_w;
   float_t     result_w;
   logic [4:0] flags_w;
   logic       issue_req;
   logic       load;
   logic       expired;
   logic       capture;
   logic       busy;
   logic       done;

   fpu_wb_regs fpu_wb_regs_inst (
      .clk(clk), .nrst(nrst),
      .cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_w(dat_w), .sel(sel),
      .dat_r(dat_r), .ack(ack),
      .opa(opa_w), .opb(opb_w), .op(op_w), .frm(frm_w),
      .issue_req(issue_req), .capture(capture), .busy(busy), .done(done),
      .result(result_w), .flags(flags_w)
   );

   fpu_seq_fsm fpu_seq_fsm_inst (
      .clk(clk), .nrst(nrst), .issue_req(issue_req), .expired(expired),
      .load(load), .capture(capture), .busy(busy), .done(done)
   );

   fpu_latency_timer fpu_latency_timer_inst (
      .clk(clk), .nrst(nrst), .load(load), .expired(expired)
   );

   fpu_pipe fpu_pipe_inst (
      .clk(clk), .nrst(nrst), .opa(opa_w), .opb(opb_w), .op(op_w), .frm(frm_w),
      .result(result_w), .flags(flags_w)
   );

endmodule

// File: verif/fpu_assert.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus handshake and status checks for the fpu register block
// bound into fpu_wb_regs by the bind at the end
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module fpu_assert (
   input logic clk,
   input logic nrst,
   input logic cyc,
   input logic stb,
   input logic ack,
   input logic issue_req,
   input logic busy,
   input logic done
);

   // ack answers a request from the cycle before
   a_ack_req: assert property (@(posedge clk) disable iff (!nrst)
      ack |-> $past(cyc && stb))
      else $error("ack without a cyc/stb request in the previous cycle");

   // single cycle ack
   a_ack_pulse: assert property (@(posedge clk) disable iff (!nrst)
      ack |=> !ack)
      else $error("ack high for two cycles in a row");

   // accepted ctrl write starts the sequencer, old done cleared
   a_issue_busy: assert property (@(posedge clk) disable iff (!nrst)
      issue_req |=> (busy && !done))
      else $error("issued op not busy, or done still set, one cycle later");

endmodule

bind fpu_wb_regs fpu_assert fpu_assert_inst (
   .clk(clk), .nrst(nrst), .cyc(cyc), .stb(stb),
   .ack(ack), .issue_req(issue_req), .busy(busy), .done(done)
);

// File: verif/fpu_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the wishbone fpu coprocessor
// bus tasks, register checks, table of float ops in a loop
// top module fpu_tb, sources from project.f
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "fpu_config.svh"

module fpu_tb;
   import fpu_float_pkg::*;
   import fpu_bus_pkg::*;

   localparam int ACK_LIMIT  = 20;     // cycles per access
   localparam int POLL_LIMIT = 40;     // status reads per op

   logic               clk;
   logic               nrst;
   logic               cyc;
   logic               stb;
   logic               we;
   logic [`FPU_AW-1:0] adr;
   logic [31:0]        dat_w;
   logic [3:0]         sel;
   logic [31:0]        dat_r;
   logic               ack;

   int n_checks;
   int n_err;
   int n_tmo;

   // stimulus table, hand computed expectations
   string       t_name[$];
   logic [31:0] t_opa[$];
   logic [31:0] t_opb[$];
   logic [1:0]  t_op[$];
   logic [2:0]  t_frm[$];
   logic [31:0] t_res[$];
   logic [4:0]  t_fl[$];

   fpu_wb_top fpu_wb_top_inst (
      .clk(clk), .nrst(nrst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
      .dat_w(dat_w), .sel(sel), .dat_r(dat_r), .ack(ack)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;          // 20 ns period
   end

   task automatic add_row(input string name, input logic [31:0] a, input logic [31:0] b,
                          input logic [1:0] op, input logic [2:0] frm,
                          input logic [31:0] res, input logic [4:0] fl);
      t_name.push_back(name);
      t_opa.push_back(a);
      t_opb.push_back(b);
      t_op.push_back(op);
      t_frm.push_back(frm);
      t_res.push_back(res);
      t_fl.push_back(fl);
   endtask

   task automatic check_word(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
      n_checks++;
      assert (got === exp) else begin
         $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
         n_err++;
      end
   endtask

   // one classic cycle, driven on the falling edge
   task automatic bus_access(input reg_idx_t idx, input logic wr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
      int n;
      rdata = 32'd0;
      @(negedge clk);
      cyc   = 1'b1;
      stb   = 1'b1;
      we    = wr;
      adr   = {idx, 2'b00};            // word index to byte address
      dat_w = wdata;
      sel   = 4'hF;
      n     = 0;
      while (n < ACK_LIMIT) begin
         @(negedge clk);
         if (ack) break;
         n++;
      end
      if (ack) begin
         rdata = dat_r;                 // registered, stable at negedge
      end else begin
         $display("timeout: no ack for access to word %0d", idx);
         n_tmo++;
      end
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
   endtask

   task automatic wb_write(input reg_idx_t idx, input logic [31:0] wdata);
      logic [31:0] unused;
      bus_access(idx, 1'b1, wdata, unused);
   endtask

   task automatic wb_read(input reg_idx_t idx, output logic [31:0] rdata);
      bus_access(idx, 1'b0, 32'd0, rdata);
   endtask

   task automatic start_op(input logic [31:0] a, input logic [31:0] b,
                           input logic [1:0] op, input logic [2:0] frm);
      wb_write(`FPU_REG_OPA, a);
      wb_write(`FPU_REG_OPB, b);
      wb_write(`FPU_REG_CTRL, {27'd0, frm, op});   // issues the op
   endtask

   // poll STATUS until done, note whether busy showed up on the way
   task automatic wait_done(output logic [31:0] status, output logic saw_busy);
      int n;
      saw_busy = 1'b0;
      status   = 32'd0;
      for (n = 0; n < POLL_LIMIT; n++) begin
         wb_read(`FPU_REG_STATUS, status);
         if (status[ST_BUSY]) saw_busy = 1'b1;
         if (status[ST_DONE]) break;
      end
      if (!status[ST_DONE]) begin
         $display("timeout: STATUS never showed done after %0d polls", POLL_LIMIT);
         n_tmo++;
      end
   endtask

   task automatic run_row(input int i);
      logic [31:0] st;
      logic [31:0] res;
      logic        busy_seen;
      start_op(t_opa[i], t_opb[i], t_op[i], t_frm[i]);
      wait_done(st, busy_seen);
      wb_read(`FPU_REG_RESULT, res);
      check_word({t_name[i], " result"}, res, t_res[i]);
      check_word({t_name[i], " flags"}, {27'd0, st[12:8]}, {27'd0, t_fl[i]});
      check_word({t_name[i], " busy seen"}, {31'd0, busy_seen}, 32'd1);
   endtask

   // flags NV=10 OF|NX=05 UF|NX=03 NX=01
   task automatic fill_table();
      add_row("add eq exp", 32'h40400000, 32'h40000000, OP_ADD, RM_RNE, 32'h40A00000, 5'h00);
      add_row("sub eq exp", 32'h40400000, 32'h40000000, OP_SUB, RM_RNE, 32'h3F800000, 5'h00);
      add_row("add carry", 32'h3FC00000, 32'h3FE00000, OP_ADD, RM_RNE, 32'h40500000, 5'h00);
      add_row("add far", 32'h3F800000, 32'h30800000, OP_ADD, RM_RNE, 32'h3F800000, 5'h01);
      add_row("add tie", 32'h3F800000, 32'h33800000, OP_ADD, RM_RNE, 32'h3F800000, 5'h01);
      add_row("cancel", 32'hC0200000, 32'h40200000, OP_ADD, RM_RNE, 32'h00000000, 5'h00);
      add_row("neg mix", 32'hBFC00000, 32'h3F000000, OP_ADD, RM_RNE, 32'hBF800000, 5'h00);
      add_row("neg sub", 32'hBF800000, 32'h40000000, OP_SUB, RM_RNE, 32'hC0400000, 5'h00);
      add_row("sub to neg", 32'h3F800000, 32'h40000000, OP_SUB, RM_RNE, 32'hBF800000, 5'h00);
      add_row("op 3 as add", 32'h3F800000, 32'h3F800000, 2'd3, RM_RNE, 32'h40000000, 5'h00);
      add_row("mul simple", 32'h3FC00000, 32'h40200000, OP_MUL, RM_RNE, 32'h40700000, 5'h00);
      add_row("mul carry", 32'h3FC00000, 32'h3FC00000, OP_MUL, RM_RNE, 32'h40100000, 5'h00);
      add_row("mul neg", 32'hC0000000, 32'h40400000, OP_MUL, RM_RNE, 32'hC0C00000, 5'h00);
      add_row("mul neg neg", 32'hC0000000, 32'hC0400000, OP_MUL, RM_RNE, 32'h40C00000, 5'h00);
      add_row("ovf rne", 32'h71800000, 32'h71800000, OP_MUL, RM_RNE, 32'h7F800000, 5'h05);
      add_row("ovf rtz", 32'h71800000, 32'h71800000, OP_MUL, RM_RTZ, 32'h7F7FFFFF, 5'h05);
      add_row("unf", 32'h8D800000, 32'h0D800000, OP_MUL, RM_RNE, 32'h80000000, 5'h03);
      add_row("inf-inf", 32'h7F800000, 32'h7F800000, OP_SUB, RM_RNE, 32'h7FC00000, 5'h10);
      add_row("inf+-inf", 32'h7F800000, 32'hFF800000, OP_ADD, RM_RNE, 32'h7FC00000, 5'h10);
      add_row("0 x inf", 32'h00000000, 32'h7F800000, OP_MUL, RM_RNE, 32'h7FC00000, 5'h10);
      add_row("nan add", 32'h7F800001, 32'h3F800000, OP_ADD, RM_RNE, 32'h7FC00000, 5'h00);
      add_row("nan mul", 32'hFFC12345, 32'h40000000, OP_MUL, RM_RNE, 32'h7FC00000, 5'h00);
      add_row("inf+fin", 32'h7F800000, 32'h3F800000, OP_ADD, RM_RNE, 32'h7F800000, 5'h00);
      add_row("fin-inf", 32'h3F800000, 32'h7F800000, OP_SUB, RM_RNE, 32'hFF800000, 5'h00);
      // 1 + 0.75 ulp, last bit differs by mode
      add_row("rnd rne", 32'h3F800000, 32'h33C00000, OP_ADD, RM_RNE, 32'h3F800001, 5'h01);
      add_row("rnd rtz", 32'h3F800000, 32'h33C00000, OP_ADD, RM_RTZ, 32'h3F800000, 5'h01);
      add_row("rnd frm 4", 32'h3F800000, 32'h33C00000, OP_ADD, 3'd4, 32'h3F800001, 5'h01);
   endtask

   initial begin
      logic [31:0] rd;
      logic [31:0] st;
      logic [31:0] wa;
      logic [31:0] wb;
      logic        busy_seen;
      nrst     = 1'b0;
      cyc      = 1'b0;
      stb      = 1'b0;
      we       = 1'b0;
      adr      = '0;
      dat_w    = 32'd0;
      sel      = 4'h0;
      n_checks = 0;
      n_err    = 0;
      n_tmo    = 0;
      void'($urandom(34891));
      fill_table();
      repeat (4) @(negedge clk);       // 4 cycles in reset
      nrst = 1'b1;

      wb_read(`FPU_REG_STATUS, rd);
      check_word("STATUS after reset", rd, 32'd0);
      wb_read(`FPU_REG_RESULT, rd);
      check_word("RESULT after reset", rd, 32'd0);

      // operand readback
      repeat (4) begin
         wa = $urandom();
         wb = $urandom();
         wb_write(`FPU_REG_OPA, wa);
         wb_write(`FPU_REG_OPB, wb);
         wb_read(`FPU_REG_OPA, rd);
         check_word("OPA readback", rd, wa);
         wb_read(`FPU_REG_OPB, rd);
         check_word("OPB readback", rd, wb);
      end
      for (int k = 5; k < 8; k++) begin
         wb_write(reg_idx_t'(k), 32'hFFFF_FFFF);   // acked, dropped
         wb_read(reg_idx_t'(k), rd);
         check_word("unmapped word", rd, 32'd0);
      end
      wb_write(`FPU_REG_STATUS, 32'hFFFF_FFFF);    // read only
      wb_read(`FPU_REG_STATUS, rd);
      check_word("STATUS after write", rd, 32'd0);

      foreach (t_opa[i]) run_row(i);

      // second ctrl write lands while busy, mul must survive
      start_op(32'h3FC00000, 32'h40200000, OP_MUL, RM_RNE);
      wb_write(`FPU_REG_CTRL, {27'd0, 3'd1, 2'd0});
      wait_done(st, busy_seen);
      check_word("busy before done", {31'd0, busy_seen}, 32'd1);
      check_word("flags after dropped ctrl", {27'd0, st[12:8]}, 32'd0);
      wb_read(`FPU_REG_CTRL, rd);
      check_word("CTRL after dropped write", rd, 32'h0000_0002);
      wb_read(`FPU_REG_RESULT, rd);
      check_word("result after dropped ctrl", rd, 32'h40700000);

      $display("checks %0d, value errors %0d, timeouts %0d", n_checks, n_err, n_tmo);
      if (n_err == 0 && n_tmo == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

// File: project.f
+incdir+verilog
verilog/fpu_float_pkg.sv
verilog/fpu_bus_pkg.sv
verilog/fpu_pipe.sv
verilog/fpu_seq_fsm.sv
verilog/fpu_latency_timer.sv
verilog/fpu_wb_regs.sv
verilog/fpu_wb_top.sv
verif/fpu_assert.sv
verif/fpu_tb.sv

// File: Makefile
# Verilator build and run for the fpu coprocessor testbench

SIM      := verilator
VFLAGS   := --binary --timing --assert -Wno-fatal
TOP      := fpu_tb
FILELIST := project.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log

SRCS     := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS     := $(wildcard verilog/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx -- '>>> PASS' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
